//--- build.f
hdl/beam_types_pkg.sv
hdl/beam_ctrl_pkg.sv
hdl/frame_control.sv
hdl/weight_bank.sv
hdl/complex_weighter.sv
hdl/channel_combiner.sv
hdl/beamformer_top.sv
tests/beamformer_tb.sv

//--- hdl/beam_ctrl_pkg.sv
// frame tracking and beat strobe definitions of the beamformer control path
`default_nettype none

package beam_ctrl_pkg;

    // frame tracking states
    // idle waits for the first beat of a frame, active runs until a beat with last
    typedef enum logic {
        frame_idle   = 1'b0,
        frame_active = 1'b1
    } frame_state_e;

    // strobes that travel with every beat
    typedef struct packed {
        logic valid;
        logic last;
    } beat_ctrl_t;

    // register stages in the complex weighter
    // the control strobes are delayed by the same amount
    localparam int WEIGHTER_DEPTH = 2;

endpackage

`default_nettype wire

//--- hdl/beam_types_pkg.sv
// data widths and complex types of the four-channel receive beamformer
`default_nettype none

package beam_types_pkg;

    // one signed component of a channel sample
    localparam int SAMPLE_WIDTH = 16;

    // one signed component of a channel weight, Q1.7
    localparam int WEIGHT_WIDTH = 8;
    localparam int WEIGHT_FRAC_BITS = 7;

    // a full sample by weight product needs the sum of both widths
    localparam int PRODUCT_WIDTH = SAMPLE_WIDTH + WEIGHT_WIDTH;

    // rr - ii or ri + ir grows by one bit, then the weight fraction is dropped
    localparam int CHANNEL_SUM_WIDTH = PRODUCT_WIDTH + 1 - WEIGHT_FRAC_BITS;

    // two guard bits hold the sum of up to four channels without overflow
    localparam int BEAM_SUM_WIDTH = CHANNEL_SUM_WIDTH + 2;

    typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
    typedef logic signed [WEIGHT_WIDTH-1:0] weight_t;
    typedef logic signed [PRODUCT_WIDTH-1:0] product_t;
    typedef logic signed [CHANNEL_SUM_WIDTH-1:0] channel_sum_t;
    typedef logic signed [BEAM_SUM_WIDTH-1:0] beam_sum_t;

    // complex input sample, also used for the beam output
    typedef struct packed {
        sample_t re;
        sample_t im;
    } complex_sample_t;

    // complex channel weight
    typedef struct packed {
        weight_t re;
        weight_t im;
    } complex_weight_t;

    // weighted channel result after scaling back by the weight fraction
    typedef struct packed {
        channel_sum_t re;
        channel_sum_t im;
    } complex_channel_t;

endpackage

`default_nettype wire

//--- hdl/beamformer_top.sv
// four-channel narrowband receive beamformer with per-frame complex weights
`timescale 1ns/1ps
`default_nettype none

module beamformer_top #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                                              clock,
    input  logic                                              resetn,
    // one beat per rising edge with valid high, there is no back-pressure
    input  beam_ctrl_pkg::beat_ctrl_t                         in_ctrl,
    input  beam_types_pkg::complex_sample_t [NUM_CHANNELS-1:0] channel_in,
    // weights may change on any cycle, only the first beat of a frame samples them
    input  beam_types_pkg::complex_weight_t [NUM_CHANNELS-1:0] weights_in,
    output beam_ctrl_pkg::beat_ctrl_t                         out_ctrl,
    output beam_types_pkg::complex_sample_t                   beam_out
);

    import beam_types_pkg::*;
    import beam_ctrl_pkg::*;

    // high for the first valid beat of a frame
    logic weight_capture;

    // beat strobes delayed to meet the weighter results
    beat_ctrl_t aligned_ctrl;

    // weights applied to the current beat
    complex_weight_t [NUM_CHANNELS-1:0] active_weights;

    // scaled products, one per channel
    complex_channel_t [NUM_CHANNELS-1:0] channel_results;

    // frame tracking and strobe alignment
    frame_control u_frame_control (
        .clock          (clock),
        .resetn         (resetn),
        .in_ctrl        (in_ctrl),
        .weight_capture (weight_capture),
        .aligned_ctrl   (aligned_ctrl)
    );

    // weights held for the length of a frame
    weight_bank #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_weight_bank (
        .clock          (clock),
        .resetn         (resetn),
        .weight_capture (weight_capture),
        .weights_in     (weights_in),
        .active_weights (active_weights)
    );

    // one complex multiplier per channel
    // together they take WEIGHTER_DEPTH cycles, as the strobe delay line does
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_channel
        complex_weighter u_weighter (
            .clock     (clock),
            .sample_in (channel_in[ch]),
            .weight    (active_weights[ch]),
            .result    (channel_results[ch])
        );
    end

    // final sum, wrap to sample width and output register
    channel_combiner #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) u_channel_combiner (
        .clock           (clock),
        .resetn          (resetn),
        .channel_results (channel_results),
        .aligned_ctrl    (aligned_ctrl),
        .beam_out        (beam_out),
        .out_ctrl        (out_ctrl)
    );

endmodule

`default_nettype wire

//--- hdl/channel_combiner.sv
// sums the weighted channel results into one beam sample and registers the output strobes
`timescale 1ns/1ps
`default_nettype none

module channel_combiner #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                                               clock,
    input  logic                                               resetn,
    input  beam_types_pkg::complex_channel_t [NUM_CHANNELS-1:0] channel_results,
    input  beam_ctrl_pkg::beat_ctrl_t                          aligned_ctrl,
    output beam_types_pkg::complex_sample_t                    beam_out,
    output beam_ctrl_pkg::beat_ctrl_t                          out_ctrl
);

    import beam_types_pkg::*;

    // full width sums across all channels
    beam_sum_t sum_re;
    beam_sum_t sum_im;

    // every channel result is sign extended before it is added
    // four 18 bit terms cannot overflow the 20 bit sum
    always_comb begin
        sum_re = '0;
        sum_im = '0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            sum_re = sum_re + beam_sum_t'(signed'(channel_results[ch].re));
            sum_im = sum_im + beam_sum_t'(signed'(channel_results[ch].im));
        end
    end

    // the output keeps the low sample bits and so wraps instead of saturating
    // it is only meaningful while out_ctrl.valid is high
    always_ff @(posedge clock) begin
        beam_out.re <= sum_re[SAMPLE_WIDTH-1:0];
        beam_out.im <= sum_im[SAMPLE_WIDTH-1:0];
    end

    // output strobes move in step with the data register
    always_ff @(posedge clock) begin
        if (!resetn) begin
            out_ctrl <= '0;
        end else begin
            out_ctrl <= aligned_ctrl;
        end
    end

endmodule

`default_nettype wire

//--- hdl/complex_weighter.sv
// two-stage complex multiply of one channel sample by its Q1.7 weight
`timescale 1ns/1ps
`default_nettype none

module complex_weighter (
    input  logic                             clock,
    input  beam_types_pkg::complex_sample_t  sample_in,
    input  beam_types_pkg::complex_weight_t  weight,
    output beam_types_pkg::complex_channel_t result
);

    import beam_types_pkg::*;

    // signed views of the struct members
    sample_t sample_re;
    sample_t sample_im;
    weight_t weight_re;
    weight_t weight_im;

    // stage 1 products
    product_t prod_rr;
    product_t prod_ii;
    product_t prod_ri;
    product_t prod_ir;

    // exact combined parts, one bit wider than a product
    logic signed [PRODUCT_WIDTH:0] exact_re;
    logic signed [PRODUCT_WIDTH:0] exact_im;

    assign sample_re = sample_in.re;
    assign sample_im = sample_in.im;
    assign weight_re = weight.re;
    assign weight_im = weight.im;

    // stage 1 registers all four partial products
    // -32768 * -128 is 2^22 and still fits a signed 24 bit product
    always_ff @(posedge clock) begin
        prod_rr <= sample_re * weight_re;
        prod_ii <= sample_im * weight_im;
        prod_ri <= sample_re * weight_im;
        prod_ir <= sample_im * weight_re;
    end

    // (a + jb)(c + jd) = (ac - bd) + j(ad + bc)
    assign exact_re = prod_rr - prod_ii;
    assign exact_im = prod_ri + prod_ir;

    // stage 2 drops the weight fraction bits
    // cutting low bits off a two's complement value is an arithmetic shift with floor
    always_ff @(posedge clock) begin
        result.re <= exact_re[PRODUCT_WIDTH:WEIGHT_FRAC_BITS];
        result.im <= exact_im[PRODUCT_WIDTH:WEIGHT_FRAC_BITS];
    end

endmodule

`default_nettype wire

//--- hdl/frame_control.sv
// frame tracking FSM that issues the weight capture strobe and aligns the beat strobes
`timescale 1ns/1ps
`default_nettype none

module frame_control (
    input  logic                      clock,
    input  logic                      resetn,
    input  beam_ctrl_pkg::beat_ctrl_t in_ctrl,
    output logic                      weight_capture,
    output beam_ctrl_pkg::beat_ctrl_t aligned_ctrl
);

    import beam_ctrl_pkg::*;

    frame_state_e state;
    frame_state_e state_next;

    // strobe delay line, one entry per weighter register stage
    beat_ctrl_t [WEIGHTER_DEPTH-1:0] strobe_pipe;

    // a single-beat frame carries last on its first beat and so never leaves idle
    always_comb begin
        state_next = state;
        case (state)
            frame_idle: begin
                if (in_ctrl.valid && !in_ctrl.last) begin
                    state_next = frame_active;
                end
            end
            frame_active: begin
                if (in_ctrl.valid && in_ctrl.last) begin
                    state_next = frame_idle;
                end
            end
            default: begin
                state_next = frame_idle;
            end
        endcase
    end

    // every valid beat seen in idle is the first beat of a frame
    // the weight bank stores its weights on this same edge
    assign weight_capture = in_ctrl.valid && (state == frame_idle);

    always_ff @(posedge clock) begin
        if (!resetn) begin
            state       <= frame_idle;
            strobe_pipe <= '0;
        end else begin
            state <= state_next;
            // last only counts on a valid beat
            strobe_pipe[0].valid <= in_ctrl.valid;
            strobe_pipe[0].last  <= in_ctrl.valid && in_ctrl.last;
            for (int i = 1; i < WEIGHTER_DEPTH; i++) begin
                strobe_pipe[i] <= strobe_pipe[i-1];
            end
        end
    end

    // the last entry lines up with the weighter results
    assign aligned_ctrl = strobe_pipe[WEIGHTER_DEPTH-1];

endmodule

`default_nettype wire

//--- hdl/weight_bank.sv
// per-channel complex weight store that holds the weights of a frame's first beat
`timescale 1ns/1ps
`default_nettype none

module weight_bank #(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                                              clock,
    input  logic                                              resetn,
    input  logic                                              weight_capture,
    input  beam_types_pkg::complex_weight_t [NUM_CHANNELS-1:0] weights_in,
    output beam_types_pkg::complex_weight_t [NUM_CHANNELS-1:0] active_weights
);

    import beam_types_pkg::*;

    // weights taken at the first beat of the running frame
    complex_weight_t [NUM_CHANNELS-1:0] stored_weights;

    // each channel keeps its own register pair
    // the ports may change on any cycle, only a capture pulse lets them in
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_weight
        always_ff @(posedge clock) begin
            if (!resetn) begin
                stored_weights[ch] <= '0;
            end else if (weight_capture) begin
                stored_weights[ch] <= weights_in[ch];
            end
        end
    end

    // the first beat of a frame is multiplied in the same cycle as it is captured
    // so it takes the live weights, all later beats take the stored set
    always_comb begin
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            if (weight_capture) begin
                active_weights[ch] = weights_in[ch];
            end else begin
                active_weights[ch] = stored_weights[ch];
            end
        end
    end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build the beamformer testbench with Verilator, run it and scan the log for failure
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing -Wno-fatal -f build.f --top-module beamformer_tb \
    -o beamformer_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/beamformer_sim > sim.log 2>&1
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation reported failure"; exit 1; } || exit 0

//--- tests/beamformer_tb.sv
// randomized testbench of the beamformer with a frame-tracking reference model
`timescale 1ns/1ps
`default_nettype none

module beamformer_tb;

    import beam_types_pkg::*;
    import beam_ctrl_pkg::*;

    localparam int NUM_CHANNELS = 4;
    localparam int RUN_CYCLES = 3000;
    // a beat driven after edge k is sampled at k+1 and shows up after edge k+3
    localparam int LATENCY = 3;
    // watchdog limit, twice the clock period per cycle plus a margin
    localparam int WATCHDOG_NS = RUN_CYCLES * 20 + 1000;

    // one output beat the model expects, with the cycle it must appear in
    typedef struct packed {
        sample_t     re;
        sample_t     im;
        logic        last;
        logic [31:0] due;
    } expect_t;

    logic                               clock;
    logic                               resetn;
    beat_ctrl_t                         in_ctrl;
    complex_sample_t [NUM_CHANNELS-1:0] channel_in;
    complex_weight_t [NUM_CHANNELS-1:0] weights_in;
    beat_ctrl_t                         out_ctrl;
    complex_sample_t                    beam_out;

    logic [15:0] lfsr;
    logic [31:0] cycle;
    expect_t     expect_q[$];
    int          beats_checked;

    // model frame tracking, mirrors the DUT frame rule
    logic                               model_active;
    complex_weight_t [NUM_CHANNELS-1:0] model_weights;
    int                                 frame_left;
    int                                 reset_left;
    logic                               mid_reset_done;

    beamformer_top #(
        .NUM_CHANNELS (NUM_CHANNELS)
    ) DUT (
        .clock      (clock),
        .resetn     (resetn),
        .in_ctrl    (in_ctrl),
        .channel_in (channel_in),
        .weights_in (weights_in),
        .out_ctrl   (out_ctrl),
        .beam_out   (beam_out)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        abort_run();
    end

    // Fibonacci LFSR with taps 16, 14, 13 and 11, one step per bit
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [15:0] draw_bits(input int count);
        logic [15:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[14:0], next_bit()};
        end
        return value;
    endfunction

    // one draw in eight gives the most negative value
    function automatic sample_t draw_sample();
        sample_t value;
        if (draw_bits(3) == 16'd0) begin
            value = 16'h8000;
        end else begin
            value = draw_bits(16);
        end
        return value;
    endfunction

    function automatic weight_t draw_weight();
        logic [15:0] raw;
        weight_t     value;
        if (draw_bits(3) == 16'd0) begin
            value = 8'h80;
        end else begin
            raw = draw_bits(8);
            value = raw[7:0];
        end
        return value;
    endfunction

    // stretches of random, back-to-back and sparse traffic take turns
    function automatic logic pick_valid(input int c);
        logic pick;
        case ((c / 250) % 3)
            0:       pick = (draw_bits(2) != 16'd0);
            1:       pick = 1'b1;
            default: pick = (draw_bits(4) == 16'd0);
        endcase
        return pick;
    endfunction

    // (a + jb)(c + jd) per channel, each part floored by the Q1.7 fraction, then summed
    function automatic complex_sample_t model_beam(
        input complex_sample_t [NUM_CHANNELS-1:0] samples,
        input complex_weight_t [NUM_CHANNELS-1:0] w
    );
        int              acc_re;
        int              acc_im;
        int              s_re;
        int              s_im;
        int              w_re;
        int              w_im;
        complex_sample_t beam;
        acc_re = 0;
        acc_im = 0;
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            s_re = int'(samples[ch].re);
            s_im = int'(samples[ch].im);
            w_re = int'(w[ch].re);
            w_im = int'(w[ch].im);
            acc_re = acc_re + ((s_re * w_re - s_im * w_im) >>> WEIGHT_FRAC_BITS);
            acc_im = acc_im + ((s_re * w_im + s_im * w_re) >>> WEIGHT_FRAC_BITS);
        end
        // only the low sample bits survive, the output wraps
        beam.re = acc_re[15:0];
        beam.im = acc_im[15:0];
        return beam;
    endfunction

    task automatic abort_run();
        $display(">>> FAIL");
        $fatal(1, "run stopped on error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h at cycle %0d",
                     name, actual, expected, cycle);
            abort_run();
        end
    endtask

    // outputs are sampled 1 ns after the edge, where they are stable
    task automatic check_outputs();
        expect_t head;
        logic    due_now;
        due_now = (expect_q.size() > 0) && (expect_q[0].due == cycle);
        if (out_ctrl.valid === 1'b1 && expect_q.size() == 0) begin
            $display("an output beat arrived at cycle %0d with no beat in flight", cycle);
            abort_run();
        end
        check_value("out_ctrl.valid", {31'd0, out_ctrl.valid}, {31'd0, due_now});
        if (due_now) begin
            head = expect_q.pop_front();
            check_value("beam_out.re", {16'd0, beam_out.re}, {16'd0, head.re});
            check_value("beam_out.im", {16'd0, beam_out.im}, {16'd0, head.im});
            check_value("out_ctrl.last", {31'd0, out_ctrl.last}, {31'd0, head.last});
            beats_checked++;
        end else begin
            check_value("out_ctrl.last", {31'd0, out_ctrl.last}, 32'd0);
        end
    endtask

    task automatic drive_cycle(input int c);
        expect_t         entry;
        complex_sample_t expected_beam;
        logic            take;
        logic            last;
        // samples and weights move on every cycle, mid-frame weight changes included
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            channel_in[ch].re = draw_sample();
            channel_in[ch].im = draw_sample();
            weights_in[ch].re = draw_weight();
            weights_in[ch].im = draw_weight();
        end
        // one reset in the middle of a frame, half way through the run
        if (!mid_reset_done && c >= RUN_CYCLES / 2 && model_active) begin
            reset_left = 3;
            mid_reset_done = 1'b1;
        end
        if (reset_left > 0) begin
            reset_left--;
            resetn = 1'b0;
            in_ctrl = '0;
            // the reset flushes every beat still in flight
            expect_q.delete();
            model_active = 1'b0;
            frame_left = 0;
        end else begin
            resetn = 1'b1;
            take = pick_valid(c);
            // the last few cycles stay idle so the pipeline drains
            if (c >= RUN_CYCLES - 8) begin
                take = 1'b0;
            end
            if (take) begin
                if (frame_left == 0) begin
                    frame_left = int'(draw_bits(3)) + 1;
                end
                last = (frame_left == 1);
                frame_left--;
                // first beat of a frame uses and keeps the weights on the ports
                if (!model_active) begin
                    model_weights = weights_in;
                end
                expected_beam = model_beam(channel_in, model_weights);
                entry.re = expected_beam.re;
                entry.im = expected_beam.im;
                entry.last = last;
                entry.due = cycle + LATENCY;
                expect_q.push_back(entry);
                model_active = !last;
            end else begin
                // last without valid is noise the DUT must ignore
                last = draw_bits(1) != 16'd0;
            end
            in_ctrl.valid = take;
            in_ctrl.last = last;
        end
    endtask

    initial begin
        lfsr = 16'd64;
        resetn = 1'b0;
        in_ctrl = '0;
        channel_in = '0;
        weights_in = '0;
        cycle = '0;
        beats_checked = 0;
        model_active = 1'b0;
        model_weights = '0;
        frame_left = 0;
        // together with time zero this holds reset for three edges
        reset_left = 2;
        mid_reset_done = 1'b0;
        for (int c = 0; c < RUN_CYCLES; c++) begin
            @(posedge clock);
            #1;
            cycle = cycle + 1;
            check_outputs();
            drive_cycle(c);
        end
        if (expect_q.size() != 0) begin
            $display("%0d expected output beats never arrived", expect_q.size());
            abort_run();
        end else begin
            $display("checked %0d output beats", beats_checked);
            $display(">>> PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
